//--- verilog.f
logic/offcal_pkg.sv
logic/offcal_csr.sv
logic/offcal_search.sv
logic/offcal_base_master.sv
logic/offcal_top.sv
verif/offcal_base_model.sv
verif/offcal_tb.sv

//--- verif/offcal_tb.sv
// testbench for the offset cancellation top level that runs directed calibration tests against a comparator model
`default_nettype none

module offcal_tb
    import offcal_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CHANNELS    = 4;
    localparam int SETTLE_CYCLES   = 3;
    localparam int NUM_RUNS        = 5;
    localparam int WATCHDOG_CYCLES = NUM_CHANNELS * 7 * (SETTLE_CYCLES + 10) * NUM_RUNS + 2000;

    logic                           reconfig_clk;
    logic                           rst_n;
    csr_addr_t                      address;
    word_t                          writedata;
    logic                           write;
    logic                           read;
    word_t                          readdata;
    logic                           waitrequest;
    logic                           done;
    base_addr_t                     base_address;
    word_t                          base_writedata;
    logic                           base_write;
    logic                           base_waitrequest;
    logic [NUM_CHANNELS*8-1:0]      test_bus;
    logic                           arb_req;
    logic                           arb_grant;
    logic                           grant_en;
    logic                           stall_en;
    logic [NUM_CHANNELS*CODE_W-1:0] targets;

    offset_code_t tgt [NUM_CHANNELS];  // targets currently loaded in the model
    int           chan0_selects;       // accepted channel 0 select writes
    int unsigned  rand_seed;

    offcal_top #(
        .NUM_CHANNELS  (NUM_CHANNELS),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) offcal_top_i (
        .reconfig_clk     (reconfig_clk),
        .rst_n            (rst_n),
        .address          (address),
        .writedata        (writedata),
        .write            (write),
        .read             (read),
        .readdata         (readdata),
        .waitrequest      (waitrequest),
        .done             (done),
        .base_address     (base_address),
        .base_writedata   (base_writedata),
        .base_write       (base_write),
        .base_waitrequest (base_waitrequest),
        .test_bus         (test_bus),
        .arb_req          (arb_req),
        .arb_grant        (arb_grant)
    );

    offcal_base_model #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) offcal_base_model_i (
        .reconfig_clk     (reconfig_clk),
        .rst_n            (rst_n),
        .base_address     (base_address),
        .base_writedata   (base_writedata),
        .base_write       (base_write),
        .base_waitrequest (base_waitrequest),
        .test_bus         (test_bus),
        .arb_grant        (arb_grant),
        .grant_en         (grant_en),
        .stall_en         (stall_en),
        .targets          (targets)
    );

    initial
    begin
        reconfig_clk = 1'b0;
        forever #50 reconfig_clk = ~reconfig_clk;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic compare_code(input offset_code_t got, input offset_code_t exp,
                                input string what);
        if (got !== exp)
            stop_with_failure($sformatf("mismatch at %0d ns: %s is %0d, expected %0d",
                                        $time, what, got, exp));
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("mismatch at %0d ns: %s is 0x%08h, expected 0x%08h",
                                        $time, what, got, exp));
    endtask

    // largest code whose comparator stays low
    function automatic offset_code_t expected_code(input offset_code_t target);
        offset_code_t best;
        best = '0;
        for (int c = 0; c < 2**CODE_W; c++)
            if (!(c > target))
                best = offset_code_t'(c);
        return best;
    endfunction

    task automatic host_write(input csr_addr_t a, input word_t d);
        @(posedge reconfig_clk);
        address   <= a;
        writedata <= d;
        write     <= 1'b1;
        @(posedge reconfig_clk);
        write <= 1'b0;  // taken in its first cycle
    endtask

    task automatic host_read(input csr_addr_t a, output word_t d);
        int waited;
        waited = 0;
        @(posedge reconfig_clk);
        address <= a;
        read    <= 1'b1;
        @(negedge reconfig_clk);
        while (waitrequest && (waited < 8))
        begin
            waited++;
            @(negedge reconfig_clk);
        end
        if (waitrequest)
            stop_with_failure("host read was never released by waitrequest");
        else
        begin
            compare_word(word_t'(waited), 32'd1, "host read wait cycles");
            d = readdata;
            @(posedge reconfig_clk);
            read <= 1'b0;
        end
    endtask

    task automatic apply_targets();
        @(posedge reconfig_clk);
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            targets[ch*CODE_W +: CODE_W] <= tgt[ch];
    endtask

    task automatic random_targets();
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            tgt[ch] = offset_code_t'($urandom % 64);
        apply_targets();
    endtask

    task automatic wait_done(input bit check_arb);
        @(negedge reconfig_clk);
        while (!done)
        begin
            if (check_arb && !arb_req)
                stop_with_failure("arb_req dropped while calibration was still running");
            @(negedge reconfig_clk);
        end
        if (check_arb)
            compare_word(word_t'(arb_req), '0, "arb_req after done");
    endtask

    task automatic check_results(input string tag);
        word_t d;
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
        begin
            host_write(CSR_CHANNEL, word_t'(ch));
            host_read(CSR_RESULT, d);
            compare_code(d[CODE_W-1:0], expected_code(tgt[ch]),
                         $sformatf("%s result of channel %0d", tag, ch));
        end
    endtask

    task automatic reset_defaults();
        word_t d;
        host_read(CSR_STATUS, d);
        compare_word(d, '0, "status after reset");
        compare_word(word_t'(done), '0, "done port after reset");
        compare_word(word_t'(arb_req), '0, "arb_req after reset");
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            tgt[ch] = '0;  // results reset to zero
        check_results("reset");
        host_read(3'd5, d);
        compare_word(d, '0, "unused address");
        host_read(CSR_CONTROL, d);
        compare_word(d, '0, "control readback");
    endtask

    task automatic basic_calibration();
        word_t d;
        random_targets();
        host_write(CSR_CONTROL, 32'h1);
        wait_done(1'b0);
        host_read(CSR_STATUS, d);
        compare_word(d, 32'h2, "status after basic run");
        check_results("basic");
    endtask

    task automatic edge_target_calibration();
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
        begin
            case (ch % 3)
                0:       tgt[ch] = 6'd0;
                1:       tgt[ch] = 6'd63;
                default: tgt[ch] = 6'd32;
            endcase
        end
        apply_targets();
        host_write(CSR_CONTROL, 32'h1);
        wait_done(1'b0);
        check_results("edge");
    endtask

    task automatic backpressure_calibration();
        word_t d;
        random_targets();
        @(posedge reconfig_clk);
        grant_en <= 1'b0;
        stall_en <= 1'b1;
        host_write(CSR_CONTROL, 32'h1);
        repeat (20) @(posedge reconfig_clk);  // engine stalls without grant
        host_read(CSR_STATUS, d);
        compare_word(d, 32'h1, "status while grant withheld");
        @(negedge reconfig_clk);
        compare_word(word_t'(arb_req), 32'h1, "arb_req while busy");
        @(posedge reconfig_clk);
        grant_en <= 1'b1;
        wait_done(1'b1);
        @(posedge reconfig_clk);
        stall_en <= 1'b0;
        check_results("backpressure");
    endtask

    task automatic control_rules();
        word_t d;
        random_targets();
        chan0_selects = 0;
        host_write(CSR_CONTROL, 32'h1);
        host_read(CSR_STATUS, d);
        compare_word(d, 32'h1, "status while busy");
        repeat (30) @(posedge reconfig_clk);
        host_write(CSR_CONTROL, 32'h1);  // ignored while the first run is busy
        wait_done(1'b0);
        compare_word(word_t'(chan0_selects), 32'd1, "channel 0 selects in one run");
        host_read(CSR_STATUS, d);
        compare_word(d, 32'h2, "status after first run");
        check_results("first");
        random_targets();
        host_write(CSR_CONTROL, 32'h1);
        host_read(CSR_STATUS, d);
        compare_word(d, 32'h1, "status after restart");
        wait_done(1'b0);
        check_results("second");
    endtask

    // bus monitor on the base port
    always @(negedge reconfig_clk)
    begin
        if (rst_n && base_write && !arb_grant)
            stop_with_failure("base write issued while the arbiter grant was low");
        else if (base_write && !base_waitrequest && (base_address == BASE_CHANNEL)
                 && (base_writedata == '0))
            chan0_selects++;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge reconfig_clk);
        stop_with_failure($sformatf("timeout, tests did not end within %0d cycles",
                                    WATCHDOG_CYCLES));
    end

    initial
    begin
        rand_seed = 32'h6178_1976;
        void'($urandom(rand_seed));
        rst_n         = 1'b0;
        address       = '0;
        writedata     = '0;
        write         = 1'b0;
        read          = 1'b0;
        grant_en      = 1'b1;
        stall_en      = 1'b0;
        targets       = '0;
        chan0_selects = 0;
        repeat (4) @(posedge reconfig_clk);
        rst_n <= 1'b1;

        reset_defaults();
        basic_calibration();
        edge_target_calibration();
        backpressure_calibration();
        control_rules();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/offcal_base_model.sv
// behavioral base reconfiguration port and comparator model, drives test_bus from the written trims
`default_nettype none

module offcal_base_model
    import offcal_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
)
(
    input  wire logic                           reconfig_clk,
    input  wire logic                           rst_n,

    input  wire base_addr_t                     base_address,
    input  wire word_t                          base_writedata,
    input  wire logic                           base_write,
    output      logic                           base_waitrequest,

    output      logic [NUM_CHANNELS*8-1:0]      test_bus,
    output      logic                           arb_grant,

    // testbench controls
    input  wire logic                           grant_en,
    input  wire logic                           stall_en,  // random waitrequest when high
    input  wire logic [NUM_CHANNELS*CODE_W-1:0] targets    // offset of each channel
);

    timeunit 1ns;
    timeprecision 100ps;

    int           sel;  // channel picked by the last BASE_CHANNEL write
    offset_code_t trims [NUM_CHANNELS];

    assign arb_grant = grant_en;

    always_comb
    begin
        test_bus = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            test_bus[ch*8] = (trims[ch] > targets[ch*CODE_W +: CODE_W]);  // trim above offset
    end

    always @(posedge reconfig_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sel              <= 0;
            base_waitrequest <= 1'b0;
            for (int ch = 0; ch < NUM_CHANNELS; ch++)
                trims[ch] <= '0;
        end
        else
        begin
            base_waitrequest <= stall_en && (($urandom % 2) == 1);
            if (base_write && !base_waitrequest)
            begin
                if (base_address == BASE_CHANNEL)
                    sel <= int'(base_writedata);
                else if ((base_address == BASE_TRIM) && (sel < NUM_CHANNELS))
                    trims[sel] <= base_writedata[CODE_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/offcal_top.sv
// offset cancellation top level, joins the host register block, search engine and base port master
`default_nettype none

module offcal_top
    import offcal_pkg::*;
#(
    parameter int NUM_CHANNELS  = 4,
    parameter int SETTLE_CYCLES = 3
)
(
    input  wire logic                      reconfig_clk,
    input  wire logic                      rst_n,

    // host avalon-mm slave
    input  wire csr_addr_t                 address,
    input  wire word_t                     writedata,
    input  wire logic                      write,
    input  wire logic                      read,
    output      word_t                     readdata,
    output      logic                      waitrequest,
    output      logic                      done,

    // base reconfiguration port
    output      base_addr_t                base_address,
    output      word_t                     base_writedata,
    output      logic                      base_write,
    input  wire logic                      base_waitrequest,

    input  wire logic [NUM_CHANNELS*8-1:0] test_bus,

    output      logic                      arb_req,
    input  wire logic                      arb_grant
);

    localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    logic            start;
    logic            busy;
    logic            finish;
    logic            session;
    logic            result_valid;
    logic [CH_W-1:0] result_channel;
    offset_code_t    result_code;
    base_req_t       base_req;
    logic            req_valid;
    logic            req_ready;

    offcal_csr #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) offcal_csr_i (
        .reconfig_clk   (reconfig_clk),
        .rst_n          (rst_n),
        .address        (address),
        .writedata      (writedata),
        .write          (write),
        .read           (read),
        .readdata       (readdata),
        .waitrequest    (waitrequest),
        .start          (start),
        .busy           (busy),
        .finish         (finish),
        .result_valid   (result_valid),
        .result_channel (result_channel),
        .result_code    (result_code),
        .done           (done)
    );

    offcal_search #(
        .NUM_CHANNELS  (NUM_CHANNELS),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) offcal_search_i (
        .reconfig_clk   (reconfig_clk),
        .rst_n          (rst_n),
        .start          (start),
        .busy           (busy),
        .session        (session),
        .finish         (finish),
        .result_valid   (result_valid),
        .result_channel (result_channel),
        .result_code    (result_code),
        .base_req       (base_req),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .test_bus       (test_bus)
    );

    offcal_base_master offcal_base_master_i (
        .reconfig_clk     (reconfig_clk),
        .rst_n            (rst_n),
        .session          (session),
        .base_req         (base_req),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .arb_req          (arb_req),
        .arb_grant        (arb_grant),
        .base_address     (base_address),
        .base_writedata   (base_writedata),
        .base_write       (base_write),
        .base_waitrequest (base_waitrequest)
    );

endmodule

`default_nettype wire

//--- logic/offcal_base_master.sv
// avalon-mm write master to the base reconfiguration port, with arbiter request and waitrequest hold
`default_nettype none

module offcal_base_master
    import offcal_pkg::*;
(
    input  wire logic       reconfig_clk,
    input  wire logic       rst_n,

    // search engine side
    input  wire logic       session,
    input  wire base_req_t  base_req,
    input  wire logic       req_valid,
    output      logic       req_ready,

    // fabric arbiter
    output      logic       arb_req,
    input  wire logic       arb_grant,

    // base reconfiguration port
    output      base_addr_t base_address,
    output      word_t      base_writedata,
    output      logic       base_write,
    input  wire logic       base_waitrequest
);

    base_req_t held_req;  // registered copy of the accepted request
    logic      pending;   // write outstanding on the base port
    logic      take;

    assign take = req_valid && arb_grant && !pending;

    assign base_write     = pending;
    assign base_address   = held_req.address;
    assign base_writedata = held_req.writedata;

    // base accepts when waitrequest drops
    assign req_ready = pending && !base_waitrequest;

    always_ff @(posedge reconfig_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending <= 1'b0;
            arb_req <= 1'b0;
        end
        else
        begin
            arb_req <= session;  // held for the whole run
            if (take)
                pending <= 1'b1;
            else if (req_ready)
                pending <= 1'b0;
        end
    end

    always_ff @(posedge reconfig_clk)
    begin
        if (take)
            held_req <= base_req;
    end

endmodule

`default_nettype wire

//--- logic/offcal_search.sv
// successive-approximation offset search over all channels, drives base writes and samples the test bus
`default_nettype none

module offcal_search
    import offcal_pkg::*;
#(
    parameter int NUM_CHANNELS  = 4,
    parameter int SETTLE_CYCLES = 3,  // at least 1
    localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
)
(
    input  wire logic                      reconfig_clk,
    input  wire logic                      rst_n,

    input  wire logic                      start,
    output      logic                      busy,
    output      logic                      session,
    output      logic                      finish,

    output      logic                      result_valid,
    output      logic [CH_W-1:0]           result_channel,
    output      offset_code_t              result_code,

    output      base_req_t                 base_req,
    output      logic                      req_valid,
    input  wire logic                      req_ready,

    input  wire logic [NUM_CHANNELS*8-1:0] test_bus
);

    localparam int CNT_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
    localparam int BIT_W = $clog2(CODE_W);

    typedef enum logic [2:0] {
        IDLE,
        SELECT,  // point the base port at the channel
        TRIAL,   // write the trial trim code
        SETTLE,
        SAMPLE,
        STORE,
        FINISH
    } search_state_t;

    search_state_t    state;
    logic [CH_W-1:0]  chan;
    logic [BIT_W-1:0] bit_idx;
    logic [CNT_W-1:0] settle_cnt;
    offset_code_t     code;
    offset_code_t     trial_code;
    logic             cmp;

    assign trial_code = code | (offset_code_t'(1) << bit_idx);
    assign cmp        = test_bus[chan * 8];  // comparator of the current channel

    assign busy           = (state != IDLE);
    assign session        = busy && (state != FINISH);
    assign finish         = (state == FINISH);
    assign result_valid   = (state == STORE);
    assign result_channel = chan;
    assign result_code    = code;
    assign req_valid      = (state == SELECT) || (state == TRIAL);

    // request held steady by the state until req_ready
    always_comb
    begin
        base_req = '0;
        if (state == SELECT)
        begin
            base_req.address   = BASE_CHANNEL;
            base_req.writedata = word_t'(chan);
        end
        else if (state == TRIAL)
        begin
            base_req.address   = BASE_TRIM;
            base_req.writedata = word_t'(trial_code);
        end
    end

    always_ff @(posedge reconfig_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            chan       <= '0;
            bit_idx    <= '0;
            settle_cnt <= '0;
            code       <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        chan  <= '0;
                        state <= SELECT;
                    end
                end
                SELECT:
                begin
                    if (req_ready)
                    begin
                        code    <= '0;
                        bit_idx <= BIT_W'(CODE_W - 1);  // msb first
                        state   <= TRIAL;
                    end
                end
                TRIAL:
                begin
                    if (req_ready)
                    begin
                        settle_cnt <= CNT_W'(SETTLE_CYCLES - 1);
                        state      <= (SETTLE_CYCLES > 1) ? SETTLE : SAMPLE;
                    end
                end
                SETTLE:
                begin
                    if (settle_cnt == CNT_W'(1))
                        state <= SAMPLE;  // lands SETTLE_CYCLES after req_ready
                    else
                        settle_cnt <= settle_cnt - 1'b1;
                end
                SAMPLE:
                begin
                    if (!cmp)
                        code <= trial_code;  // trial not above offset, keep the bit
                    if (bit_idx == '0)
                        state <= STORE;
                    else
                    begin
                        bit_idx <= bit_idx - 1'b1;
                        state   <= TRIAL;
                    end
                end
                STORE:
                begin
                    if (chan == CH_W'(NUM_CHANNELS - 1))
                        state <= FINISH;
                    else
                    begin
                        chan  <= chan + 1'b1;
                        state <= SELECT;
                    end
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/offcal_csr.sv
// host avalon-mm register block, starts calibration and holds the per-channel result codes
`default_nettype none

module offcal_csr
    import offcal_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
)
(
    input  wire logic            reconfig_clk,
    input  wire logic            rst_n,

    // host slave
    input  wire csr_addr_t       address,
    input  wire word_t           writedata,
    input  wire logic            write,
    input  wire logic            read,
    output      word_t           readdata,
    output      logic            waitrequest,

    // search engine
    output      logic            start,
    input  wire logic            busy,
    input  wire logic            finish,
    input  wire logic            result_valid,
    input  wire logic [CH_W-1:0] result_channel,
    input  wire offset_code_t    result_code,

    output      logic            done
);

    offset_code_t    codes [NUM_CHANNELS];
    logic [CH_W-1:0] chan_sel;
    logic            done_q;
    logic            rd_pending;  // second cycle of a host read
    word_t           rd_word;

    // a start request is dropped while a run is in progress
    assign start = write && (address == CSR_CONTROL) && writedata[0] && !busy;

    assign waitrequest = read && !rd_pending;  // one wait cycle per read
    assign done        = done_q;

    always_comb
    begin
        rd_word = '0;
        case (address)
            CSR_STATUS:  rd_word[1:0] = {done_q, busy};
            CSR_CHANNEL: rd_word[CH_W-1:0] = chan_sel;
            CSR_RESULT:
            begin
                if (chan_sel < NUM_CHANNELS)
                    rd_word[CODE_W-1:0] = codes[chan_sel];
            end
            default:     rd_word = '0;  // control is write only
        endcase
    end

    always_ff @(posedge reconfig_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_pending <= 1'b0;
            readdata   <= '0;
            chan_sel   <= '0;
            done_q     <= 1'b0;
            for (int i = 0; i < NUM_CHANNELS; i++)
                codes[i] <= '0;
        end
        else
        begin
            rd_pending <= read && !rd_pending;
            if (read && !rd_pending)
                readdata <= rd_word;  // valid while waitrequest is low

            if (write && (address == CSR_CHANNEL))
                chan_sel <= writedata[CH_W-1:0];

            if (start)
                done_q <= 1'b0;
            else if (finish)
                done_q <= 1'b1;

            if (result_valid)
                codes[result_channel] <= result_code;
        end
    end

endmodule

`default_nettype wire

//--- logic/offcal_pkg.sv
// shared widths, base request struct and register map for the offset cancellation subsystem
`default_nettype none

package offcal_pkg;

    localparam int CODE_W = 6;  // trim code width

    typedef logic [CODE_W-1:0] offset_code_t;
    typedef logic [31:0]       word_t;       // avalon data word, host and base side
    typedef logic [2:0]        csr_addr_t;
    typedef logic [2:0]        base_addr_t;

    // one write towards the base reconfiguration port
    typedef struct packed {
        base_addr_t address;
        word_t      writedata;
    } base_req_t;

    // host register map
    localparam csr_addr_t CSR_CONTROL = 3'd0;  // bit 0 starts calibration
    localparam csr_addr_t CSR_STATUS  = 3'd1;  // bit 0 busy, bit 1 done
    localparam csr_addr_t CSR_CHANNEL = 3'd2;  // readback channel select
    localparam csr_addr_t CSR_RESULT  = 3'd3;  // code of the selected channel

    // base port register map
    localparam base_addr_t BASE_CHANNEL = 3'd0;  // logical channel select
    localparam base_addr_t BASE_TRIM    = 3'd1;  // trim code of selected channel

endpackage

`default_nettype wire
